//--- bpu_params.svh
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// data path and pc width
`define XLEN 32

// set index of the bht and btb, taken from pc above bit 3
// 4 gives 16 sets, enough for simulation
`define BHT_INDEX_WIDTH 4

// entries in each training-record fifo
`define UPDATE_FIFO_DEPTH 4

// width of each outcome counter, wraps at the top
`define PMU_CNT_WIDTH 32

`endif

//--- bju_pkg.sv
package bju_pkg;

    // control-transfer kind, signedness folded into the kind
    typedef enum logic [2:0] {
        JAL  = 3'd0,
        JALR = 3'd1,
        BEQ  = 3'd2,
        BNE  = 3'd3,
        BLT  = 3'd4,  // signed
        BGE  = 3'd5,  // signed
        BLTU = 3'd6,
        BGEU = 3'd7
    } cx_kind_t;

    // resolved direction against predicted direction and target
    // values double as the pmu counter offset within a kind group
    typedef enum logic [2:0] {
        TAKEN_RIGHT          = 3'd0,
        TAKEN_WRONG_TARGET   = 3'd1,
        TAKEN_PRED_NOT_TAKEN = 3'd2,
        NOT_TAKEN_PRED_TAKEN = 3'd3,
        NOT_TAKEN_RIGHT      = 3'd4
    } outcome_t;

    localparam int NUM_OUTCOMES = 5;

endpackage

//--- bpu_pkg.sv
package bpu_pkg;

`include "bpu_params.svh"

    // one counter step for the bht
    typedef struct packed {
        logic [`BHT_INDEX_WIDTH-1:0] set_index;
        logic [1:0]                  slot;  // pc[3:2]
        logic                        up;    // 1 steps toward taken
    } bht_update_t;

    // target write into one btb slot
    typedef struct packed {
        logic [`BHT_INDEX_WIDTH-1:0] set_index;
        logic [1:0]                  slot;
        logic [`XLEN-1:0]            target;
    } btb_write_t;

    // four instruction slots per set
    localparam int SLOTS_PER_SET = 4;

endpackage

//--- bju.sv
`timescale 1ns/1ns
`include "bpu_params.svh"

module bju
    import bju_pkg::*;
    import bpu_pkg::*;
(
    input  logic             clock,
    input  logic             reset_n,
    input  logic             resolve_valid,
    input  cx_kind_t         cx_kind,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] pc,
    input  logic             predict_taken,
    input  logic [`XLEN-1:0] predict_target,
    input  logic             bht_full,
    input  logic             btb_full,
    output logic             resolve_ready,
    output logic [`XLEN-1:0] dest,
    output logic             redirect_valid,
    output logic [`XLEN-1:0] redirect_target,
    output outcome_t         outcome,
    output logic             accepted,
    output logic             is_jump,
    output logic             bht_push,
    output bht_update_t      bht_rec,
    output logic             btb_push,
    output btb_write_t       btb_rec
);

    logic             equal;
    logic             less_s;
    logic             less_u;
    logic             taken;
    logic             mispredict;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] pc_plus4;

    assign equal  = (src1 == src2);
    assign less_s = ($signed(src1) < $signed(src2));
    assign less_u = (src1 < src2);

    always_comb begin
        case (cx_kind)
            JAL, JALR: taken = 1'b1;
            BEQ:       taken = equal;
            BNE:       taken = !equal;
            BLT:       taken = less_s;
            BGE:       taken = !less_s;
            BLTU:      taken = less_u;
            BGEU:      taken = !less_u;
            default:   taken = 1'b0;
        endcase
    end

    assign is_jump  = (cx_kind == JAL) || (cx_kind == JALR);
    assign target   = (cx_kind == JALR) ? src1 + imm : pc + imm;
    assign pc_plus4 = pc + `XLEN'd4;
    assign dest     = pc_plus4;  // link value

    always_comb begin
        if (taken && predict_taken && (target == predict_target)) begin
            outcome = TAKEN_RIGHT;
        end else if (taken && predict_taken) begin
            outcome = TAKEN_WRONG_TARGET;
        end else if (taken) begin
            outcome = TAKEN_PRED_NOT_TAKEN;
        end else if (predict_taken) begin
            outcome = NOT_TAKEN_PRED_TAKEN;
        end else begin
            outcome = NOT_TAKEN_RIGHT;
        end
    end

    assign mispredict = (outcome != TAKEN_RIGHT) && (outcome != NOT_TAKEN_RIGHT);

    // any instruction may carry a btb record so both fifos need room
    assign resolve_ready = !bht_full && !btb_full;
    assign accepted      = resolve_valid && resolve_ready;

    assign redirect_valid  = accepted && mispredict;
    assign redirect_target = taken ? target : pc_plus4;  // fall through on wrong taken guess

    assign bht_push          = accepted;
    assign bht_rec.set_index = pc[`BHT_INDEX_WIDTH+3:4];
    assign bht_rec.slot      = pc[3:2];
    assign bht_rec.up        = taken;

    assign btb_push          = accepted && taken && mispredict;
    assign btb_rec.set_index = pc[`BHT_INDEX_WIDTH+3:4];
    assign btb_rec.slot      = pc[3:2];
    assign btb_rec.target    = target;

    a_redirect_needs_accept: assert property (
        @(posedge clock) disable iff (!reset_n)
            redirect_valid |-> (resolve_valid && !bht_full && !btb_full)
    );

    a_btb_with_bht: assert property (
        @(posedge clock) disable iff (!reset_n) btb_push |-> bht_push
    );

endmodule

//--- update_fifo.sv
`timescale 1ns/1ns
`include "bpu_params.svh"

module update_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int DEPTH = `UPDATE_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];  // payload only, no reset
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);  // both at once leaves it
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clock) disable iff (!reset_n) !(push && full)
    );

endmodule

//--- bht_btb.sv
`timescale 1ns/1ns
`include "bpu_params.svh"

module bht_btb
    import bpu_pkg::*;
(
    input  logic             clock,
    input  logic             reset_n,
    input  logic             bht_empty,
    input  bht_update_t      bht_data,
    input  logic             btb_empty,
    input  btb_write_t       btb_data,
    input  logic [`XLEN-1:0] lookup_pc,
    output logic             bht_pop,
    output logic             btb_pop,
    output logic [1:0]       lookup_counter,
    output logic             lookup_hit,
    output logic [`XLEN-1:0] lookup_target
);

    localparam int SETS = 1 << `BHT_INDEX_WIDTH;

    logic [1:0]                  bht_cnt    [SETS][SLOTS_PER_SET];
    logic                        btb_valid  [SETS][SLOTS_PER_SET];
    logic [`XLEN-1:0]            btb_target [SETS][SLOTS_PER_SET];  // no reset, guarded by valid
    logic [`BHT_INDEX_WIDTH-1:0] lookup_set;
    logic [1:0]                  lookup_slot;
    logic [1:0]                  cur_cnt;

    // drain one record of each kind per cycle
    assign bht_pop = !bht_empty;
    assign btb_pop = !btb_empty;

    assign cur_cnt = bht_cnt[bht_data.set_index][bht_data.slot];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int k = 0; k < SLOTS_PER_SET; k++) begin
                    bht_cnt[s][k]   <= 2'b01;  // weakly not-taken
                    btb_valid[s][k] <= 1'b0;
                end
            end
        end else begin
            if (bht_pop) begin
                if (bht_data.up && (cur_cnt != 2'b11)) begin
                    bht_cnt[bht_data.set_index][bht_data.slot] <= cur_cnt + 2'b01;
                end else if (!bht_data.up && (cur_cnt != 2'b00)) begin
                    bht_cnt[bht_data.set_index][bht_data.slot] <= cur_cnt - 2'b01;
                end
            end
            if (btb_pop) begin
                btb_valid[btb_data.set_index][btb_data.slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (btb_pop) begin
            btb_target[btb_data.set_index][btb_data.slot] <= btb_data.target;
        end
    end

    assign lookup_set  = lookup_pc[`BHT_INDEX_WIDTH+3:4];
    assign lookup_slot = lookup_pc[3:2];

    assign lookup_counter = bht_cnt[lookup_set][lookup_slot];
    assign lookup_hit     = btb_valid[lookup_set][lookup_slot];
    assign lookup_target  = btb_target[lookup_set][lookup_slot];

endmodule

//--- pmu_apb.sv
`timescale 1ns/1ns
`include "bpu_params.svh"

module pmu_apb
    import bju_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      accepted,
    input  logic                      is_jump,
    input  outcome_t                  outcome,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`XLEN-1:0]          paddr,
    output logic [`PMU_CNT_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr
);

    localparam int NUM_CNT = 2 * NUM_OUTCOMES;  // b-type group then j-type group

    logic [`PMU_CNT_WIDTH-1:0] cnt [NUM_CNT];
    logic [3:0]                inc_idx;
    logic [`XLEN-3:0]          word;
    logic                      addr_ok;
    logic                      access;

    assign inc_idx = is_jump ? 4'(NUM_OUTCOMES) + 4'(outcome) : 4'(outcome);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else if (accepted) begin
            cnt[inc_idx] <= cnt[inc_idx] + 1'b1;  // wraps
        end
    end

    // zero wait state slave, read only
    assign access  = psel && penable;
    assign word    = paddr[`XLEN-1:2];
    assign addr_ok = (paddr[1:0] == 2'b00) && (word < (`XLEN-2)'(NUM_CNT));

    assign pready  = 1'b1;
    assign pslverr = access && (pwrite || !addr_ok);
    assign prdata  = (access && !pwrite && addr_ok) ? cnt[word[3:0]] : '0;

    a_penable_needs_psel: assert property (
        @(posedge clock) disable iff (!reset_n) penable |-> psel
    );

endmodule

//--- branch_unit_top.sv
`timescale 1ns/1ns
`include "bpu_params.svh"

module branch_unit_top
    import bju_pkg::*;
    import bpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      resolve_valid,
    input  cx_kind_t                  cx_kind,
    input  logic [`XLEN-1:0]          src1,
    input  logic [`XLEN-1:0]          src2,
    input  logic [`XLEN-1:0]          imm,
    input  logic [`XLEN-1:0]          pc,
    input  logic                      predict_taken,
    input  logic [`XLEN-1:0]          predict_target,
    output logic                      resolve_ready,
    output logic [`XLEN-1:0]          dest,
    output logic                      redirect_valid,
    output logic [`XLEN-1:0]          redirect_target,
    output outcome_t                  outcome,
    input  logic [`XLEN-1:0]          lookup_pc,
    output logic [1:0]                lookup_counter,
    output logic                      lookup_hit,
    output logic [`XLEN-1:0]          lookup_target,
    output logic                      tables_idle,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`XLEN-1:0]          paddr,
    output logic [`PMU_CNT_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic        accepted;
    logic        is_jump;
    logic        bht_push;
    logic        bht_pop;
    logic        bht_full;
    logic        bht_empty;
    bht_update_t bht_rec;
    bht_update_t bht_head;
    logic        btb_push;
    logic        btb_pop;
    logic        btb_full;
    logic        btb_empty;
    btb_write_t  btb_rec;
    btb_write_t  btb_head;

    assign tables_idle = bht_empty && btb_empty;  // all training applied

    bju u_bju (
        .clock           (clock),
        .reset_n         (reset_n),
        .resolve_valid   (resolve_valid),
        .cx_kind         (cx_kind),
        .src1            (src1),
        .src2            (src2),
        .imm             (imm),
        .pc              (pc),
        .predict_taken   (predict_taken),
        .predict_target  (predict_target),
        .bht_full        (bht_full),
        .btb_full        (btb_full),
        .resolve_ready   (resolve_ready),
        .dest            (dest),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .outcome         (outcome),
        .accepted        (accepted),
        .is_jump         (is_jump),
        .bht_push        (bht_push),
        .bht_rec         (bht_rec),
        .btb_push        (btb_push),
        .btb_rec         (btb_rec)
    );

    update_fifo #(.payload_t(bht_update_t)) u_bht_fifo (
        .clock     (clock),
        .reset_n   (reset_n),
        .push      (bht_push),
        .push_data (bht_rec),
        .pop       (bht_pop),
        .pop_data  (bht_head),
        .full      (bht_full),
        .empty     (bht_empty)
    );

    update_fifo #(.payload_t(btb_write_t)) u_btb_fifo (
        .clock     (clock),
        .reset_n   (reset_n),
        .push      (btb_push),
        .push_data (btb_rec),
        .pop       (btb_pop),
        .pop_data  (btb_head),
        .full      (btb_full),
        .empty     (btb_empty)
    );

    bht_btb u_tables (
        .clock          (clock),
        .reset_n        (reset_n),
        .bht_empty      (bht_empty),
        .bht_data       (bht_head),
        .btb_empty      (btb_empty),
        .btb_data       (btb_head),
        .lookup_pc      (lookup_pc),
        .bht_pop        (bht_pop),
        .btb_pop        (btb_pop),
        .lookup_counter (lookup_counter),
        .lookup_hit     (lookup_hit),
        .lookup_target  (lookup_target)
    );

    pmu_apb u_pmu (
        .clock    (clock),
        .reset_n  (reset_n),
        .accepted (accepted),
        .is_jump  (is_jump),
        .outcome  (outcome),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

endmodule

//--- tb_branch_unit.sv
`timescale 1ns/1ns
`include "bpu_params.svh"

module tb_branch_unit
    import bju_pkg::*;
();

    localparam int SETS = 1 << `BHT_INDEX_WIDTH;

    logic                      clock;
    logic                      reset_n;
    logic                      resolve_valid;
    cx_kind_t                  cx_kind;
    logic [`XLEN-1:0]          src1;
    logic [`XLEN-1:0]          src2;
    logic [`XLEN-1:0]          imm;
    logic [`XLEN-1:0]          pc;
    logic                      predict_taken;
    logic [`XLEN-1:0]          predict_target;
    logic                      resolve_ready;
    logic [`XLEN-1:0]          dest;
    logic                      redirect_valid;
    logic [`XLEN-1:0]          redirect_target;
    outcome_t                  outcome;
    logic [`XLEN-1:0]          lookup_pc;
    logic [1:0]                lookup_counter;
    logic                      lookup_hit;
    logic [`XLEN-1:0]          lookup_target;
    logic                      tables_idle;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`XLEN-1:0]          paddr;
    logic [`PMU_CNT_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;

    integer                    seed;
    outcome_t                  last_class;

    // reference state
    logic [1:0]                m_cnt    [SETS][4];
    logic                      m_valid  [SETS][4];
    logic [`XLEN-1:0]          m_target [SETS][4];
    logic [`PMU_CNT_WIDTH-1:0] m_pmu    [10];

    branch_unit_top DUT (.*);

    always #4 clock = ~clock;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("=== FAIL ===");
        $fatal(1, "timeout: %s", what);
    endtask

    function automatic logic model_taken(cx_kind_t k, logic [31:0] a, logic [31:0] b);
        case (k)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b1;  // jal and jalr always go
        endcase
    endfunction

    // boundary values mixed with plain random words
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'h7fff_ffff;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h0;
            default: return $random(seed);
        endcase
    endfunction

    task automatic resolve_one(input cx_kind_t k, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] im, input logic [31:0] p,
                               input logic pt, input logic [31:0] ptgt);
        logic        taken;
        logic [31:0] tgt;
        outcome_t    cls;
        int          waited;
        int          set_i;
        int          slot_i;
        taken = model_taken(k, a, b);
        tgt   = (k == JALR) ? a + im : p + im;
        if (taken) begin
            cls = !pt ? TAKEN_PRED_NOT_TAKEN : (tgt == ptgt) ? TAKEN_RIGHT : TAKEN_WRONG_TARGET;
        end else begin
            cls = pt ? NOT_TAKEN_PRED_TAKEN : NOT_TAKEN_RIGHT;
        end
        @(negedge clock);
        resolve_valid  = 1'b1;
        cx_kind        = k;
        src1           = a;
        src2           = b;
        imm            = im;
        pc             = p;
        predict_taken  = pt;
        predict_target = ptgt;
        #1;
        waited = 0;
        while (!resolve_ready) begin  // only an edge with ready counts
            waited++;
            if (waited > 40) begin
                timeout_abort("resolve_ready stayed low");
            end
            @(negedge clock);
            #1;
        end
        check(dest, p + 32'd4, "dest");
        check(32'(outcome), 32'(cls), "outcome class");
        if (cls == TAKEN_WRONG_TARGET || cls == TAKEN_PRED_NOT_TAKEN) begin
            check(redirect_valid, 1'b1, "redirect_valid on taken mispredict");
            check(redirect_target, tgt, "redirect_target to branch target");
        end else if (cls == NOT_TAKEN_PRED_TAKEN) begin
            check(redirect_valid, 1'b1, "redirect_valid on wrong taken guess");
            check(redirect_target, p + 32'd4, "redirect_target to fall through");
        end else begin
            check(redirect_valid, 1'b0, "redirect_valid on correct prediction");
        end
        last_class = outcome;  // as seen from the DUT
        @(posedge clock);
        set_i  = int'(p[7:4]);
        slot_i = int'(p[3:2]);
        if (taken && m_cnt[set_i][slot_i] != 2'b11) begin
            m_cnt[set_i][slot_i] = m_cnt[set_i][slot_i] + 2'b01;
        end else if (!taken && m_cnt[set_i][slot_i] != 2'b00) begin
            m_cnt[set_i][slot_i] = m_cnt[set_i][slot_i] - 2'b01;
        end
        if (taken && cls != TAKEN_RIGHT) begin
            m_valid[set_i][slot_i]  = 1'b1;
            m_target[set_i][slot_i] = tgt;
        end
        m_pmu[((k == JAL || k == JALR) ? 5 : 0) + int'(cls)] += 1;
    endtask

    task automatic drop_valid();
        @(negedge clock);
        resolve_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!tables_idle) begin
            waited++;
            if (waited > 40) begin
                timeout_abort("training fifos never drained");
            end
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    task automatic probe_entry(input int s, input int k);
        @(negedge clock);
        lookup_pc = 32'((s << 4) | (k << 2));
        #1;
        check(lookup_counter, m_cnt[s][k], $sformatf("bht counter set %0d slot %0d", s, k));
        check(lookup_hit, m_valid[s][k], $sformatf("btb valid set %0d slot %0d", s, k));
        if (m_valid[s][k]) begin
            check(lookup_target, m_target[s][k], $sformatf("btb target set %0d slot %0d", s, k));
        end
    endtask

    task automatic compare_tables();
        for (int s = 0; s < SETS; s++) begin
            for (int k = 0; k < 4; k++) begin
                probe_entry(s, k);
            end
        end
    endtask

    task automatic apb_access(input logic [31:0] addr, input logic wr,
                              output logic [31:0] data, output logic err);
        int waited;
        waited = 0;
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        @(negedge clock);
        penable = 1'b1;
        #1;
        while (!pready) begin
            waited++;
            if (waited > 20) begin
                timeout_abort("pready stayed low");
            end
            @(negedge clock);
            #1;
        end
        data = prdata;
        err  = pslverr;
        @(negedge clock);  // access phase closed at the edge before
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic sweep_kinds();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] p;
        logic [31:0] r;
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < 8; i++) begin
                a  = pick_operand();
                b  = (i % 3 == 0) ? a : pick_operand();
                im = $random(seed) & 32'hffff_fffe;
                p  = $random(seed) & 32'hffff_fffc;
                r  = $random(seed);
                resolve_one(cx_kind_t'(k), a, b, im, p, r[0],
                            r[1] ? ((k == int'(JALR)) ? a + im : p + im) : $random(seed));
            end
        end
        drop_valid();
    endtask

    task automatic cover_classes();
        cx_kind_t k;
        for (int j = 0; j < 2; j++) begin
            k = (j == 0) ? BEQ : JAL;  // b-type pass then j-type pass
            resolve_one(k, 32'd5, 32'd5, 32'h40, 32'h0000_0510, 1'b1, 32'h0000_0550);
            check(32'(last_class), 32'(TAKEN_RIGHT), "class taken right");
            resolve_one(k, 32'd5, 32'd5, 32'h40, 32'h0000_0510, 1'b1, 32'h0000_0600);
            check(32'(last_class), 32'(TAKEN_WRONG_TARGET), "class wrong target");
            resolve_one(k, 32'd5, 32'd5, 32'h40, 32'h0000_0510, 1'b0, 32'h0);
            check(32'(last_class), 32'(TAKEN_PRED_NOT_TAKEN), "class predicted not-taken");
        end
        resolve_one(BEQ, 32'd5, 32'd6, 32'h40, 32'h0000_0520, 1'b1, 32'h0000_0560);
        check(32'(last_class), 32'(NOT_TAKEN_PRED_TAKEN), "class predicted taken");
        resolve_one(BEQ, 32'd5, 32'd6, 32'h40, 32'h0000_0520, 1'b0, 32'h0);
        check(32'(last_class), 32'(NOT_TAKEN_RIGHT), "class not-taken right");
        drop_valid();
    endtask

    task automatic train_counters();
        wait_idle();
        compare_tables();
        // correct taken guesses on set 3 slot 1 train only the bht
        for (int i = 0; i < 4; i++) begin
            resolve_one(BNE, 32'd1, 32'd2, 32'h80, 32'h0000_0234, 1'b1, 32'h0000_02b4);
            drop_valid();
            wait_idle();
            probe_entry(3, 1);
        end
        resolve_one(BLT, 32'hffff_fff0, 32'd3, 32'h100, 32'h0000_0234, 1'b0, 32'h0);
        drop_valid();
        wait_idle();
        probe_entry(3, 1);
        for (int i = 0; i < 5; i++) begin
            resolve_one(BGEU, 32'd1, 32'd2, 32'h80, 32'h0000_0234, 1'b0, 32'h0);
            drop_valid();
            wait_idle();
            probe_entry(3, 1);
        end
        compare_tables();
    endtask

    task automatic burst_mispredicts();
        for (int i = 0; i < 16; i++) begin
            resolve_one(JAL, $random(seed), $random(seed), 32'h0000_0800 + 32'(i * 8),
                        32'h0000_1000 + 32'(i * 4), 1'b0, 32'h0);
        end
        drop_valid();
        wait_idle();
        compare_tables();
    endtask

    task automatic read_pmu();
        logic [31:0] data;
        logic        err;
        for (int w = 0; w < 10; w++) begin
            apb_access(32'(w * 4), 1'b0, data, err);
            check(err, 1'b0, $sformatf("pslverr on read of word %0d", w));
            check(data, m_pmu[w], $sformatf("pmu counter word %0d", w));
        end
        apb_access(32'h0, 1'b1, data, err);
        check(err, 1'b1, "pslverr on write");
        check(data, 32'h0, "read data on write");
        apb_access(32'd40, 1'b0, data, err);
        check(err, 1'b1, "pslverr on word 10");
        check(data, 32'h0, "read data on word 10");
    endtask

    initial begin
        seed           = 62684;
        clock          = 1'b0;
        reset_n        = 1'b0;
        resolve_valid  = 1'b0;
        cx_kind        = JAL;
        src1           = '0;
        src2           = '0;
        imm            = '0;
        pc             = '0;
        predict_taken  = 1'b0;
        predict_target = '0;
        lookup_pc      = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int k = 0; k < 4; k++) begin
                m_cnt[s][k]    = 2'b01;
                m_valid[s][k]  = 1'b0;
                m_target[s][k] = '0;
            end
        end
        for (int i = 0; i < 10; i++) begin
            m_pmu[i] = '0;
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        sweep_kinds();
        cover_classes();
        train_counters();
        burst_mispredicts();
        read_pmu();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
bju_pkg.sv
bpu_pkg.sv
bju.sv
update_fifo.sv
bht_btb.sv
pmu_apb.sv
branch_unit_top.sv
tb_branch_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_branch_unit
FILELIST  := all.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) bpu_params.svh
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
